/* files.f */
+incdir+logic
logic/usb_tx_pkg.sv
logic/bit_timer.sv
logic/byte_shifter.sv
logic/bit_stuffer.sv
logic/nrzi_encoder.sv
logic/tx_control.sv
logic/byte_transmitter.sv
bench/tb_byte_transmitter.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -Wall
TOP       ?= tb_byte_transmitter
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

SRCS := $(shell grep -v '^+' $(FILELIST)) logic/usb_tx_settings.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then exit 1; fi
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tb_byte_transmitter.sv */
/*
 * Byte transmitter testbench
 * Table of packets, FIFO model and line decoder with NRZI and destuffing
 */

`timescale 1ns/1ps

`include "usb_tx_settings.svh"

module tb_byte_transmitter import usb_tx_pkg::*;
();

	localparam int NROWS = 6;

	logic  clk;
	logic  arst_n;
	logic  tx_start;
	byte_t pid;
	byte_t fifo_byte;
	logic  fifo_empty;
	logic  byte_req;
	logic  busy;
	logic  d_plus;
	logic  d_minus;

	// Packet table
	byte_t row_pid[NROWS];
	int    row_len[NROWS];
	byte_t row_data[NROWS][16];

	// FIFO model state
	byte_t cur_payload[16];
	int    cur_len;
	int    rd_idx;
	int    req_count;
	logic  fifo_restart;

	int   cycles;
	int   limit;
	logic se1_seen;
	int   passes;
	int   fails;

	byte_transmitter dut_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.tx_start   (tx_start),
		.pid        (pid),
		.fifo_byte  (fifo_byte),
		.fifo_empty (fifo_empty),
		.byte_req   (byte_req),
		.busy       (busy),
		.d_plus     (d_plus),
		.d_minus    (d_minus)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Source advances on each byte_req, empty after the last byte
	always @(posedge clk)
	begin
		if (fifo_restart)
		begin
			rd_idx     <= 0;
			req_count  <= 0;
			fifo_byte  <= cur_payload[0];
			fifo_empty <= (cur_len == 0);
		end
		else if (byte_req)
		begin
			rd_idx     <= rd_idx + 1;
			req_count  <= req_count + 1;
			fifo_byte  <= cur_payload[(rd_idx + 1) % 16];
			fifo_empty <= (rd_idx + 1 >= cur_len);
		end
	end

	always @(posedge clk)
		cycles <= cycles + 1;

	// SE1 watch over the whole run
	always @(negedge clk)
	begin
		if (arst_n && d_plus && d_minus && !se1_seen)
		begin
			$display("[FAIL] %0t d_plus and d_minus high together", $time);
			se1_seen <= 1'b1;
		end
	end

	initial
	begin
		forever
		begin
			@(posedge clk);
			if (limit != 0 && cycles > limit)
			begin
				$display("Timeout after %0d cycles, transmitter never finished", cycles);
				$display("sim failed");
				$finish;
			end
		end
	end

	task automatic add_row(input int r, input byte_t p, input int n, input logic rnd,
		input logic [31:0] word);
		int i;
		begin
			row_pid[r] = p;
			row_len[r] = n;
			for (i = 0; i < 16; i++)
				row_data[r][i] = rnd ? byte_t'($urandom) : word[8*(i%4) +: 8];
		end
	endtask

	task automatic report(input int r, input string msg);
		begin
			$display("[FAIL] %0t row %0d: %s", $time, r, msg);
		end
	endtask

	// Decode one packet from the line and compare with the row
	task automatic decode_row(input int r, output logic bad);
		byte_t exp[$];
		byte_t got[$];
		byte_t cur;
		int    i;
		int    ones;
		int    nbits;
		int    se0n;
		logic  prev;
		logic  bitv;
		begin
			bad = 1'b0;
			// SYNC is seven zeros then a one
			exp = {8'h80, row_pid[r]};
			for (i = 0; i < row_len[r]; i++)
				exp.push_back(row_data[r][i]);
			ones  = 0;
			nbits = 0;
			se0n  = 0;
			prev  = 1'b1;
			cur   = '0;
			// First K marks SYNC
			while (!(d_plus == 1'b0 && d_minus == 1'b1))
				@(negedge clk);
			repeat (3) @(negedge clk);
			while (!(d_plus == 1'b0 && d_minus == 1'b0))
			begin
				if (!busy)
				begin
					report(r, "busy low while the packet is on the line");
					bad = 1'b1;
				end
				bitv = (d_plus == prev);
				prev = d_plus;
				if (ones == `USB_STUFF_LIMIT)
				begin
					if (bitv)
					begin
						report(r, "seven ones on the line, stuff bit missing");
						bad = 1'b1;
					end
					ones = 0;
				end
				else
				begin
					ones = bitv ? ones + 1 : 0;
					cur[nbits] = bitv;
					nbits++;
					if (nbits == 8)
					begin
						got.push_back(cur);
						nbits = 0;
					end
				end
				repeat (8) @(negedge clk);
			end
			// Six ones right before EOP still owe their zero
			if (ones == `USB_STUFF_LIMIT)
			begin
				report(r, "stuff bit missing before EOP");
				bad = 1'b1;
			end
			// Two SE0 bit times then J
			while (d_plus == 1'b0 && d_minus == 1'b0)
			begin
				se0n++;
				repeat (8) @(negedge clk);
			end
			if (se0n != `USB_EOP_SE0_BITS)
			begin
				report(r, $sformatf("%0d SE0 bit times, expected 2", se0n));
				bad = 1'b1;
			end
			if (!(d_plus == 1'b1 && d_minus == 1'b0))
			begin
				report(r, "no J state after SE0");
				bad = 1'b1;
			end
			if (nbits != 0)
			begin
				report(r, $sformatf("%0d stray bits before EOP", nbits));
				bad = 1'b1;
			end
			if (got.size() != exp.size())
			begin
				report(r, $sformatf("decoded %0d bytes, expected %0d", got.size(), exp.size()));
				bad = 1'b1;
			end
			else
				for (i = 0; i < exp.size(); i++)
					if (got[i] != exp[i])
					begin
						report(r, $sformatf("byte %0d is %h, expected %h", i, got[i], exp[i]));
						bad = 1'b1;
					end
		end
	endtask

	task automatic run_row(input int r);
		int   i;
		logic bad;
		logic start_bad;
		logic idle_bad;
		begin
			start_bad = 1'b0;
			idle_bad  = 1'b0;
			for (i = 0; i < 16; i++)
				cur_payload[i] = row_data[r][i];
			cur_len = row_len[r];
			@(posedge clk);
			fifo_restart <= 1'b1;
			@(posedge clk);
			fifo_restart <= 1'b0;
			tx_start     <= 1'b1;
			pid          <= row_pid[r];
			@(posedge clk);
			tx_start <= 1'b0;
			// busy follows the sampled start by one cycle
			@(negedge clk);
			if (!busy)
			begin
				report(r, "busy did not rise after tx_start");
				start_bad = 1'b1;
			end
			fork
				decode_row(r, bad);
				begin
					// Start strobe while busy must be ignored
					repeat (30) @(posedge clk);
					tx_start <= 1'b1;
					@(posedge clk);
					tx_start <= 1'b0;
				end
			join
			if (start_bad)
				bad = 1'b1;
			i = 0;
			while (busy && i < 8)
			begin
				@(negedge clk);
				i++;
			end
			if (busy)
			begin
				report(r, "busy still high after J bit");
				bad = 1'b1;
			end
			if (req_count != row_len[r])
			begin
				report(r, $sformatf("%0d byte_req pulses, expected %0d", req_count, row_len[r]));
				bad = 1'b1;
			end
			// Line must stay idle, no second packet
			repeat (24)
			begin
				@(negedge clk);
				if (busy || !(d_plus == 1'b1 && d_minus == 1'b0))
					idle_bad = 1'b1;
			end
			if (idle_bad)
			begin
				report(r, "line left idle J after the packet");
				bad = 1'b1;
			end
			if (bad)
			begin
				fails++;
				$display("row %0d failed", r);
			end
			else
			begin
				passes++;
				$display("row %0d ok", r);
			end
		end
	endtask

	initial
	begin
		run_all_rows();
	end

	task automatic run_all_rows();
		int r;
		begin
			arst_n       = 1'b0;
			tx_start     = 1'b0;
			pid          = '0;
			fifo_byte    = '0;
			fifo_empty   = 1'b1;
			fifo_restart = 1'b0;
			cycles       = 0;
			limit        = 0;
			se1_seen     = 1'b0;
			passes       = 0;
			fails        = 0;
			void'($urandom(24));
			add_row(0, 8'hC3, 3, 1'b0, 32'h0003_0201);
			add_row(1, 8'h4B, 0, 1'b0, 32'h0);
			add_row(2, 8'hC3, 2, 1'b0, 32'hFFFF_FFFF);
			// Six trailing ones owe a stuff bit before EOP
			add_row(3, 8'hD2, 1, 1'b0, 32'h0000_00FC);
			add_row(4, 8'h4B, 8, 1'b1, 32'h0);
			add_row(5, 8'hC3, 4, 1'b0, 32'hFF00_FF7E);
			for (r = 0; r < NROWS; r++)
				limit += 8 * (16 + 10 * row_len[r] + 8) + 200;
			limit += 50;
			repeat (5) @(posedge clk);
			arst_n <= 1'b1;
			repeat (10)
			begin
				@(negedge clk);
				if (busy || !(d_plus == 1'b1 && d_minus == 1'b0))
				begin
					$display("[FAIL] %0t line not idle J after reset", $time);
					fails++;
				end
			end
			for (r = 0; r < NROWS; r++)
				run_row(r);
			if (se1_seen)
				fails++;
			$display("rows passed %0d, failures %0d", passes, fails);
			if (fails == 0)
				$display("sim passed");
			else
				$display("sim failed");
			$finish;
		end
	endtask

endmodule

/* logic/byte_transmitter.sv */
/*
 * USB full-speed transmitter top
 * Timer, shifter, stuffer, NRZI encoder and packet controller
 */

`timescale 1ns/1ps

module byte_transmitter import usb_tx_pkg::*;
(
	input  logic  clk,
	input  logic  arst_n,
	input  logic  tx_start,
	input  byte_t pid,
	input  byte_t fifo_byte,
	input  logic  fifo_empty,
	output logic  byte_req,
	output logic  busy,
	output logic  d_plus,
	output logic  d_minus
);

	logic       run;
	logic       bit_tick;
	logic       load;
	byte_t      load_byte;
	logic       tx_bit;
	logic       byte_done;
	logic       stall;
	logic       stuffed_bit;
	logic       stuff_pending;
	line_mode_t line_mode;

	// Packet sequencing
	tx_control control_i (
		.clk           (clk),
		.arst_n        (arst_n),
		.tx_start      (tx_start),
		.pid           (pid),
		.fifo_byte     (fifo_byte),
		.fifo_empty    (fifo_empty),
		.bit_tick      (bit_tick),
		.byte_done     (byte_done),
		.stuff_pending (stuff_pending),
		.run           (run),
		.load          (load),
		.load_byte     (load_byte),
		.byte_req      (byte_req),
		.line_mode     (line_mode),
		.busy          (busy)
	);

	bit_timer timer_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.run      (run),
		.bit_tick (bit_tick)
	);

	byte_shifter shifter_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.bit_tick  (bit_tick),
		.stall     (stall),
		.load      (load),
		.load_byte (load_byte),
		.tx_bit    (tx_bit),
		.byte_done (byte_done)
	);

	bit_stuffer stuffer_i (
		.clk           (clk),
		.arst_n        (arst_n),
		.bit_tick      (bit_tick),
		.tx_bit        (tx_bit),
		.stuffed_bit   (stuffed_bit),
		.stall         (stall),
		.stuff_pending (stuff_pending)
	);

	// Line drivers
	nrzi_encoder encoder_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.bit_tick    (bit_tick),
		.stuffed_bit (stuffed_bit),
		.line_mode   (line_mode),
		.d_plus      (d_plus),
		.d_minus     (d_minus)
	);

endmodule

/* logic/tx_control.sv */
/*
 * Transmit controller
 * Sequences SYNC, PID, FIFO payload and EOP, and gates the bit timer
 */

`timescale 1ns/1ps

`include "usb_tx_settings.svh"

module tx_control import usb_tx_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       tx_start,
	input  byte_t      pid,
	input  byte_t      fifo_byte,
	input  logic       fifo_empty,
	input  logic       bit_tick,
	input  logic       byte_done,
	input  logic       stuff_pending,
	output logic       run,
	output logic       load,
	output byte_t      load_byte,
	output logic       byte_req,
	output line_mode_t line_mode,
	output logic       busy
);

	localparam int SE0_W = $clog2(`USB_EOP_SE0_BITS + 1);
	// Mode changes reach the encoder on the same tick they are made
	localparam logic [SE0_W-1:0] SE0_LAST = SE0_W'(`USB_EOP_SE0_BITS);

	tx_state_t        state;
	byte_t            pid_q;
	logic             drain;
	logic [SE0_W-1:0] se0_cnt;
	logic             j_end;
	logic             start;
	logic             in_body;
	logic             take_byte;

	// Accept a start only when idle
	assign start = (state == IDLE) && tx_start;

	// PID or payload byte in flight, no stuff wait yet
	assign in_body = ((state == PID) || (state == DATA)) && !drain;

	// Next payload byte pulled at the end of a byte
	assign take_byte = in_body && byte_done && !fifo_empty;

	// Byte staging for the shifter
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			pid_q     <= pid;
			load_byte <= `USB_SYNC_BYTE;
		end
		else if ((state == SYNC) && byte_done)
			load_byte <= pid_q;
		else if (take_byte)
			load_byte <= fifo_byte;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state     <= IDLE;
			run       <= 1'b0;
			busy      <= 1'b0;
			load      <= 1'b0;
			byte_req  <= 1'b0;
			line_mode <= LINE_J;
			drain     <= 1'b0;
			se0_cnt   <= '0;
			j_end     <= 1'b0;
		end
		else
		begin
			// Strobes last one cycle
			load     <= 1'b0;
			byte_req <= 1'b0;
			j_end    <= 1'b0;
			case (state)
				IDLE:
				begin
					if (start)
					begin
						state     <= SYNC;
						run       <= 1'b1;
						busy      <= 1'b1;
						load      <= 1'b1;
						line_mode <= LINE_DATA;
					end
				end
				SYNC:
				begin
					if (byte_done)
					begin
						state <= PID;
						load  <= 1'b1;
					end
				end
				PID, DATA:
				begin
					if (take_byte)
					begin
						state    <= DATA;
						load     <= 1'b1;
						byte_req <= 1'b1;
					end
					else if ((drain || byte_done) && !stuff_pending)
					begin
						// Source empty and nothing owed
						state     <= EOP_SE0;
						line_mode <= LINE_SE0;
						drain     <= 1'b0;
					end
					else if (byte_done)
						// Owed stuff bit goes out before EOP
						drain <= 1'b1;
				end
				EOP_SE0:
				begin
					if (bit_tick)
					begin
						if (se0_cnt == SE0_LAST)
						begin
							se0_cnt   <= '0;
							state     <= EOP_J;
							line_mode <= LINE_J;
						end
						else
							se0_cnt <= se0_cnt + 1'b1;
					end
				end
				EOP_J:
				begin
					// Release one cycle after the J tick
					if (j_end)
					begin
						state <= IDLE;
						run   <= 1'b0;
						busy  <= 1'b0;
					end
					else if (bit_tick)
						j_end <= 1'b1;
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	a_req_in_body: assert property (@(posedge clk) disable iff (!arst_n)
		byte_req |-> ($past(state) inside {PID, DATA}))
		else $error("byte_req outside PID or DATA");

endmodule

/* logic/nrzi_encoder.sv */
/*
 * NRZI encoder
 * Turns the stuffed bit stream into J and K line states, plus SE0 and idle J
 */

`timescale 1ns/1ps

module nrzi_encoder import usb_tx_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       bit_tick,
	input  logic       stuffed_bit,
	input  line_mode_t line_mode,
	output logic       d_plus,
	output logic       d_minus
);

	// Stuffed bit settles one cycle after the tick
	logic tick_q;

	// Line level, high means J
	logic lvl;
	logic data_lvl;

	// Zero toggles the line, one keeps it
	assign data_lvl = stuffed_bit ? lvl : ~lvl;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			tick_q  <= 1'b0;
			lvl     <= 1'b1;
			d_plus  <= 1'b1;
			d_minus <= 1'b0;
		end
		else
		begin
			tick_q <= bit_tick;
			if (tick_q)
			begin
				case (line_mode)
					LINE_DATA:
					begin
						lvl     <= data_lvl;
						d_plus  <= data_lvl;
						d_minus <= ~data_lvl;
					end
					LINE_SE0:
					begin
						// Both low, level kept
						d_plus  <= 1'b0;
						d_minus <= 1'b0;
					end
					default:
					begin
						// Idle J, next packet starts from J
						lvl     <= 1'b1;
						d_plus  <= 1'b1;
						d_minus <= 1'b0;
					end
				endcase
			end
		end
	end

	a_no_se1: assert property (@(posedge clk) disable iff (!arst_n)
		!(d_plus && d_minus))
		else $error("SE1 driven on the line");

endmodule

/* logic/bit_stuffer.sv */
/*
 * Bit stuffer
 * Counts runs of ones and forces a zero bit after the limit is reached
 */

`timescale 1ns/1ps

`include "usb_tx_settings.svh"

module bit_stuffer
(
	input  logic clk,
	input  logic arst_n,
	input  logic bit_tick,
	input  logic tx_bit,
	output logic stuffed_bit,
	output logic stall,
	output logic stuff_pending
);

	localparam int CNT_W = $clog2(`USB_STUFF_LIMIT + 1);
	localparam logic [CNT_W-1:0] LIMIT = CNT_W'(`USB_STUFF_LIMIT);

	logic [CNT_W-1:0] ones;
	logic             owe;

	// Shifter hold and EOP delay both follow the owed stuff bit
	assign stall         = owe;
	assign stuff_pending = owe;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ones        <= '0;
			owe         <= 1'b0;
			stuffed_bit <= 1'b1;
		end
		else if (bit_tick)
		begin
			if (owe)
			begin
				// Stuff tick, the data bit waits
				stuffed_bit <= 1'b0;
				ones        <= '0;
				owe         <= 1'b0;
			end
			else if (tx_bit)
			begin
				stuffed_bit <= 1'b1;
				ones        <= ones + 1'b1;
				owe         <= (ones == LIMIT - 1'b1);
			end
			else
			begin
				stuffed_bit <= 1'b0;
				// Any zero breaks the run
				ones        <= '0;
			end
		end
	end

	a_run_limit: assert property (@(posedge clk) disable iff (!arst_n)
		ones <= LIMIT)
		else $error("ones run exceeded stuffing limit");

endmodule

/* logic/byte_shifter.sv */
/*
 * Byte shifter
 * Presents a loaded byte one bit per tick, LSB first, holding on stuffs
 */

`timescale 1ns/1ps

module byte_shifter import usb_tx_pkg::*;
(
	input  logic  clk,
	input  logic  arst_n,
	input  logic  bit_tick,
	input  logic  stall,
	input  logic  load,
	input  byte_t load_byte,
	output logic  tx_bit,
	output logic  byte_done
);

	byte_t    sr;
	bit_idx_t idx;
	logic     advance;

	// Move on only for real data ticks
	assign advance = bit_tick && !stall;

	// Current bit is always the low end
	assign tx_bit = sr[0];

	// Data path
	always_ff @(posedge clk)
	begin
		if (load)
			sr <= load_byte;
		else if (advance)
			// Zeros fill in behind the last bit
			sr <= {1'b0, sr[7:1]};
	end

	// Position tracking
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			idx       <= '0;
			byte_done <= 1'b0;
		end
		else
		begin
			byte_done <= 1'b0;
			if (load)
				idx <= '0;
			else if (advance)
			begin
				idx <= idx + 1'b1;
				// Bit 7 just went out
				byte_done <= &idx;
			end
		end
	end

endmodule

/* logic/bit_timer.sv */
/*
 * Bit timer
 * Divides the system clock into one strobe per line bit while running
 */

`timescale 1ns/1ps

`include "usb_tx_settings.svh"

module bit_timer import usb_tx_pkg::*;
(
	input  logic clk,
	input  logic arst_n,
	input  logic run,
	output logic bit_tick
);

	// Last phase before wrap
	localparam phase_t LAST = phase_t'(`USB_BIT_PERIOD - 1);

	phase_t phase;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			phase    <= '0;
			bit_tick <= 1'b0;
		end
		else if (!run)
		begin
			// Parked at zero so the first tick follows run directly
			phase    <= '0;
			bit_tick <= 1'b0;
		end
		else
		begin
			bit_tick <= (phase == '0);
			phase    <= (phase == LAST) ? '0 : phase + 1'b1;
		end
	end

	// First tick lands on the cycle after run rises
	a_first_tick: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(run) |=> bit_tick)
		else $error("no bit_tick on the cycle after run rose");

endmodule

/* logic/usb_tx_pkg.sv */
/*
 * USB transmitter types
 * Data widths, counters and the controller state encoding
 */

`include "usb_tx_settings.svh"

package usb_tx_pkg;

	// One data byte on the bus
	typedef logic [7:0] byte_t;

	// Bit position within a byte
	typedef logic [2:0] bit_idx_t;

	// Clock phase inside one line bit
	typedef logic [$clog2(`USB_BIT_PERIOD)-1:0] phase_t;

	// Packet sequencing states
	typedef enum logic [2:0] {IDLE, SYNC, PID, DATA, EOP_SE0, EOP_J} tx_state_t;

	// What the encoder puts on the line
	typedef enum logic [1:0] {LINE_DATA, LINE_SE0, LINE_J} line_mode_t;

endpackage

/* logic/usb_tx_settings.svh */
/*
 * USB full-speed transmitter settings
 * Line timing and packet framing constants for a 96 MHz clock
 */

`ifndef USB_TX_SETTINGS_SVH
`define USB_TX_SETTINGS_SVH

// Clock cycles per line bit at 12 Mb/s
`define USB_BIT_PERIOD 8

// Consecutive ones before a zero is stuffed
`define USB_STUFF_LIMIT 6

// Seven zeros then a one, sent LSB first
`define USB_SYNC_BYTE 8'h80

// SE0 bit times in the end of packet
`define USB_EOP_SE0_BITS 2

`endif
